// ==== build.f ====
riscv_pkg.sv
mem_rw.sv
data_ram.sv
reg_file.sv
mem_wb_top.sv
tb_mem_wb_top.sv

// ==== data_ram.sv ====
// word data RAM, DMEM_WORDS must be a power of two >= 2; addresses wrap, contents not reset
`timescale 1ns/1ps

module data_ram
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic                       clk_i,
    input  logic [riscv_pkg::XLEN-1:0]  addr_i,
    input  logic                       read_i,
    input  logic [riscv_pkg::LANES-1:0] wsel_byte_i,
    input  logic [riscv_pkg::XLEN-1:0]  wdata_i,
    output logic [riscv_pkg::XLEN-1:0]  rdata_o
);

    import riscv_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    mem_word_u        mem [DMEM_WORDS];
    mem_word_u        wr_word;
    logic [IDX_W-1:0] idx;

    // word index, byte offset and upper bits dropped
    assign idx = addr_i[IDX_W+1:2];

    assign wr_word.word = wdata_i;

    // lane-wise write at the rising edge
    always_ff @(posedge clk_i)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            if (wsel_byte_i[i])
            begin
                mem[idx].bytes[i] <= wr_word.bytes[i];
            end
        end
    end

    // asynchronous read, zero when no load is active
    assign rdata_o = read_i ? mem[idx].word : '0;

endmodule : data_ram

// ==== mem_rw.sv ====
// load/store lane logic with MEM/WB registers; misaligned accesses follow the lane rule, no trap
`timescale 1ns/1ps

module mem_rw
(
    input  logic                            clk_i,
    input  logic                            rstn_i,

    // data memory side
    output logic [riscv_pkg::XLEN-1:0]       rw_addr_o,
    output logic                            read_o,
    input  logic [riscv_pkg::XLEN-1:0]       rdata_i,
    output logic [riscv_pkg::LANES-1:0]      wsel_byte_o,
    output logic [riscv_pkg::XLEN-1:0]       wdata_o,

    // from EX/MEM
    input  logic [riscv_pkg::XLEN-1:0]       alu_result_i,
    input  logic [riscv_pkg::XLEN-1:0]       alu_oper2_i,
    input  riscv_pkg::mem_oper_t             mem_oper_i,
    input  logic                            wb_use_mem_i,
    input  logic                            write_rd_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr_i,

    // MEM/WB register outputs
    output logic                            wb_use_mem_o,
    output logic                            write_rd_o,
    output logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic [riscv_pkg::XLEN-1:0]       alu_result_o,
    output logic [riscv_pkg::XLEN-1:0]       dmem_rdata_o
);

    import riscv_pkg::*;

    mem_word_u         rd_word;
    logic [1:0]        lane;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    logic [XLEN-1:0]   load_data;
    logic [LANES-1:0]  wsel_byte;
    logic [XLEN-1:0]   wdata;
    logic              read;

    assign rd_word.word = rdata_i;
    assign lane = alu_result_i[1:0];

    // addressed byte and halfword of the returned word
    assign ld_byte = rd_word.bytes[lane];
    assign ld_half = rd_word.halves[lane[1]];

    always_comb
    begin
        load_data = '0;
        wsel_byte = '0;
        wdata = '0;
        read = 1'b0;

        case (mem_oper_i)
            MEM_LB:
            begin
                read = 1'b1;
                load_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            end
            MEM_LBU:
            begin
                read = 1'b1;
                load_data = {{(XLEN-8){1'b0}}, ld_byte};
            end
            MEM_LH:
            begin
                read = 1'b1;
                load_data = {{(XLEN-16){ld_half[15]}}, ld_half};
            end
            MEM_LHU:
            begin
                read = 1'b1;
                load_data = {{(XLEN-16){1'b0}}, ld_half};
            end
            MEM_LW:
            begin
                read = 1'b1;
                load_data = rd_word.word;
            end
            // stores move the low bits of oper2 into lane position
            MEM_SB:
            begin
                wsel_byte = LANES'(1) << lane;
                wdata = alu_oper2_i << {lane, 3'b000};
            end
            MEM_SH:
            begin
                // bit 0 of the address is ignored
                wsel_byte = lane[1] ? 4'b1100 : 4'b0011;
                wdata = lane[1] ? {alu_oper2_i[15:0], 16'h0000}
                                : {16'h0000, alu_oper2_i[15:0]};
            end
            MEM_SW:
            begin
                wsel_byte = '1;
                wdata = alu_oper2_i;
            end
            default:
            begin
                // MEM_NOP and unused codes touch nothing
                read = 1'b0;
            end
        endcase
    end

    assign rw_addr_o = (mem_oper_i != MEM_NOP) ? alu_result_i : '0;
    assign read_o = read;
    assign wsel_byte_o = wsel_byte;
    assign wdata_o = wdata;

    // MEM/WB stage
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wb_use_mem_o <= 1'b0;
            write_rd_o <= 1'b0;
            rd_addr_o <= '0;
            alu_result_o <= '0;
            dmem_rdata_o <= '0;
        end
        else
        begin
            wb_use_mem_o <= wb_use_mem_i;
            write_rd_o <= write_rd_i;
            rd_addr_o <= rd_addr_i;
            alu_result_o <= alu_result_i;
            dmem_rdata_o <= load_data;
        end
    end

endmodule : mem_rw

// ==== mem_wb_top.sv ====
// MEM and WB stages of an RV32I pipeline, loads and stores only, no hazards or traps
`timescale 1ns/1ps

module mem_wb_top
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic                            clk_i,
    input  logic                            rstn_i,

    // EX/MEM values
    input  logic [riscv_pkg::XLEN-1:0]       alu_result_i,
    input  logic [riscv_pkg::XLEN-1:0]       alu_oper2_i,
    input  riscv_pkg::mem_oper_t             mem_oper_i,
    input  logic                            wb_use_mem_i,
    input  logic                            write_rd_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr_i,

    // register read ports
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [riscv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [riscv_pkg::XLEN-1:0]       rs2_data_o
);

    import riscv_pkg::*;

    // memory side
    logic [XLEN-1:0]       rw_addr;
    logic                  read;
    logic [XLEN-1:0]       rdata;
    logic [LANES-1:0]      wsel_byte;
    logic [XLEN-1:0]       wdata;

    // MEM/WB side
    logic                  wb_use_mem;
    logic                  write_rd;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       dmem_rdata;

    mem_rw u_mem_rw
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rw_addr_o    (rw_addr),
        .read_o       (read),
        .rdata_i      (rdata),
        .wsel_byte_o  (wsel_byte),
        .wdata_o      (wdata),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .mem_oper_i   (mem_oper_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .wb_use_mem_o (wb_use_mem),
        .write_rd_o   (write_rd),
        .rd_addr_o    (rd_addr),
        .alu_result_o (alu_result),
        .dmem_rdata_o (dmem_rdata)
    );

    data_ram #(.DMEM_WORDS(DMEM_WORDS)) u_data_ram
    (
        .clk_i       (clk_i),
        .addr_i      (rw_addr),
        .read_i      (read),
        .wsel_byte_i (wsel_byte),
        .wdata_i     (wdata),
        .rdata_o     (rdata)
    );

    reg_file u_reg_file
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb_use_mem_i (wb_use_mem),
        .write_rd_i   (write_rd),
        .rd_addr_i    (rd_addr),
        .alu_result_i (alu_result),
        .dmem_rdata_i (dmem_rdata),
        .rs1_addr_i   (rs1_addr_i),
        .rs2_addr_i   (rs2_addr_i),
        .rs1_data_o   (rs1_data_o),
        .rs2_data_o   (rs2_data_o)
    );

endmodule : mem_wb_top

// ==== reg_file.sv ====
// write-back mux and 32-entry register file; x0 reads zero, read ports are combinational
`timescale 1ns/1ps

module reg_file
(
    input  logic                            clk_i,
    input  logic                            rstn_i,

    // from MEM/WB
    input  logic                            wb_use_mem_i,
    input  logic                            write_rd_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]       alu_result_i,
    input  logic [riscv_pkg::XLEN-1:0]       dmem_rdata_i,

    // decode-side read ports
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [riscv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [riscv_pkg::XLEN-1:0]       rs2_data_o
);

    import riscv_pkg::*;

    localparam int NREGS = 2 ** REG_ADDR_W;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NREGS-1];
    logic [XLEN-1:0] wb_data;
    logic            wb_en;

    // write-back source
    assign wb_data = wb_use_mem_i ? dmem_rdata_i : alu_result_i;

    assign wb_en = write_rd_i && (rd_addr_i != '0);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 1; i < NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_en)
        begin
            regs[rd_addr_i] <= wb_data;
        end
    end

    // read ports
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : reg_file

// ==== riscv_pkg.sv ====
// shared RV32I memory types and widths; XLEN is fixed at 32 and lane views assume byte lanes
package riscv_pkg;

    // data path width
    localparam int XLEN = 32;

    // byte lanes per data word
    localparam int LANES = XLEN / 8;

    // register index width, 32 architectural registers
    localparam int REG_ADDR_W = 5;

    // memory operation from the EX/MEM register
    typedef enum logic [3:0]
    {
        MEM_NOP = 4'd0,
        // loads
        MEM_LB  = 4'd1,
        MEM_LBU = 4'd2,
        MEM_LH  = 4'd3,
        MEM_LHU = 4'd4,
        MEM_LW  = 4'd5,
        // stores
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

    // one memory word seen three ways
    typedef union packed
    {
        // whole word
        logic [XLEN-1:0] word;

        // byte lanes, index 0 is the lowest address
        logic [LANES-1:0][7:0] bytes;

        // halfword lanes, selected by address bit 1
        logic [LANES/2-1:0][15:0] halves;
    } mem_word_u;

endpackage : riscv_pkg

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_wb_top -f build.f -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -q "^Done: no errors$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

// ==== tb_mem_wb_top.sv ====
// random load/store testbench for mem_wb_top; RAM image fully written before random phase, fixed seed
`timescale 1ns/1ps

module tb_mem_wb_top;

    import riscv_pkg::*;

    localparam int DMEM_WORDS = 256;
    localparam int RAND_OPS = 2000;
    localparam int TIMEOUT_CYCLES = RAND_OPS + DMEM_WORDS + 100;

    logic                  clk_i;
    logic                  rstn_i;
    logic [XLEN-1:0]       alu_result_i;
    logic [XLEN-1:0]       alu_oper2_i;
    mem_oper_t             mem_oper_i;
    logic                  wb_use_mem_i;
    logic                  write_rd_i;
    logic [REG_ADDR_W-1:0] rd_addr_i;
    logic [REG_ADDR_W-1:0] rs1_addr_i;
    logic [REG_ADDR_W-1:0] rs2_addr_i;
    logic [XLEN-1:0]       rs1_data_o;
    logic [XLEN-1:0]       rs2_data_o;

    // reference state
    logic [31:0] ram_model [DMEM_WORDS];
    logic [31:0] regs_model [32];
    logic [31:0] lfsr = 32'h8974;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    // op in MEM this cycle and op held in MEM/WB
    mem_oper_t   cur_op = MEM_NOP;
    logic [31:0] cur_addr = '0;
    logic [31:0] cur_oper2 = '0;
    logic        cur_write = 1'b0;
    logic [4:0]  cur_rd = '0;
    logic [31:0] cur_data = '0;
    logic        mw_write = 1'b0;
    logic [4:0]  mw_rd = '0;
    logic [31:0] mw_data = '0;

    mem_wb_top #(.DMEM_WORDS(DMEM_WORDS)) dut
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .mem_oper_i   (mem_oper_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .rs1_addr_i   (rs1_addr_i),
        .rs2_addr_i   (rs2_addr_i),
        .rs1_data_o   (rs1_data_o),
        .rs2_data_o   (rs2_data_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #5 clk_i = ~clk_i;
        end
    end

    // taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] read_model(logic [4:0] idx);
        return (idx == 5'd0) ? 32'h0 : regs_model[idx];
    endfunction

    // lane picked from the byte address, word wraps on the RAM depth
    function automatic logic [31:0] load_value(mem_oper_t op, logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ram_model[int'((addr >> 2) % DMEM_WORDS)];
        b = 8'(w >> (addr[1:0] * 8));
        h = 16'(w >> (addr[1] * 16));
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            MEM_LW:  return w;
            default: return 32'h0;
        endcase
    endfunction

    function automatic void apply_store(mem_oper_t op, logic [31:0] addr, logic [31:0] data);
        int idx;
        idx = int'((addr >> 2) % DMEM_WORDS);
        if (op == MEM_SB)
            ram_model[idx][addr[1:0] * 8 +: 8] = data[7:0];
        else if (op == MEM_SH)
            ram_model[idx][addr[1] * 16 +: 16] = data[15:0];
        else if (op == MEM_SW)
            ram_model[idx] = data;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one cycle: model the edge, drive the next op, check read ports mid-cycle
    task automatic step(mem_oper_t op, logic [31:0] alu, logic [31:0] oper2, logic use_mem,
                        logic wr, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        @(posedge clk_i);
        if (mw_write)
            regs_model[mw_rd] = mw_data;
        mw_write = cur_write;
        mw_rd = cur_rd;
        mw_data = cur_data;
        apply_store(cur_op, cur_addr, cur_oper2);
        #1;
        mem_oper_i = op;
        alu_result_i = alu;
        alu_oper2_i = oper2;
        wb_use_mem_i = use_mem;
        write_rd_i = wr;
        rd_addr_i = rd;
        rs1_addr_i = rs1;
        rs2_addr_i = rs2;
        cur_op = op;
        cur_addr = alu;
        cur_oper2 = oper2;
        cur_write = wr && (rd != 5'd0);
        cur_rd = rd;
        cur_data = use_mem ? load_value(op, alu) : alu;
        @(negedge clk_i);
        check_value("rs1_data_o", read_model(rs1), rs1_data_o);
        check_value("rs2_data_o", read_model(rs2), rs2_data_o);
    endtask

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: test did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        mem_oper_t   op;
        logic [31:0] alu;
        logic [31:0] prev_addr;
        logic        use_mem;
        prev_addr = '0;
        rstn_i = 1'b0;
        mem_oper_i = MEM_NOP;
        alu_result_i = '0;
        alu_oper2_i = '0;
        wb_use_mem_i = 1'b0;
        write_rd_i = 1'b0;
        rd_addr_i = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        for (int i = 0; i < 32; i++)
            regs_model[i] = '0;
        repeat (10) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        // fill every RAM word, registers stay zero and are swept on both ports
        for (int i = 0; i < DMEM_WORDS; i++)
            step(MEM_SW, 32'(i * 4), rand_bits(32), 1'b0, 1'b0, 5'd0, 5'(i), 5'(~i));

        for (int n = 0; n < RAND_OPS; n++)
        begin
            op = mem_oper_t'(4'(rand_bits(4) % 9));
            alu = rand_bits(32);
            if (op != MEM_NOP)
            begin
                // often hit the previous word again with another lane
                if (rand_bits(2) == 0)
                    alu = {prev_addr[31:2], 2'(rand_bits(2))};
                else
                    alu = alu % (DMEM_WORDS * 4);
                prev_addr = alu;
            end
            use_mem = (op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW})
                      && (rand_bits(3) != 0);
            step(op, alu, rand_bits(32), use_mem, rand_bits(2) != 0, 5'(rand_bits(5)),
                 5'(rand_bits(5)), 5'(rand_bits(5)));
        end

        // drain the pipeline
        for (int i = 0; i < 3; i++)
            step(MEM_NOP, 32'h0, 32'h0, 1'b0, 1'b0, 5'd0, 5'(rand_bits(5)), 5'(rand_bits(5)));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : tb_mem_wb_top
